//--- src/imuldiv_params.svh
// widths shared by the multiply/divide unit
// operand, request tag and iteration counter sizes

`ifndef IMULDIV_PARAMS_SVH
`define IMULDIV_PARAMS_SVH

// --------------------
// datapath widths
// --------------------

// operand word, fixed by the core
`define IMULDIV_XLEN 32

// request tag carried back with each response
`define IMULDIV_TAG_W 4

// iteration counter, wide enough to count XLEN steps
`define IMULDIV_CNT_W 6

`endif

//--- src/imuldiv_data_pkg.sv
// vector types for operands, results, tags and counters

`default_nettype none

`include "imuldiv_params.svh"

package imuldiv_data_pkg;

  // one operand
  typedef logic [`IMULDIV_XLEN-1:0] word_t;

  // full result, or a widened partial product
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;

  // request identifier
  typedef logic [`IMULDIV_TAG_W-1:0] tag_t;

  // iteration counter
  typedef logic [`IMULDIV_CNT_W-1:0] count_t;

endpackage

`default_nettype wire

//--- src/imuldiv_ctrl_pkg.sv
// function codes and iterative state machine encoding

`default_nettype none

package imuldiv_ctrl_pkg;

  // requested operation
  // fn_div is signed, fn_divu unsigned
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } fn_t;

  // shared by multiplier control and divider
  // idle -> calc on accept, calc -> done after XLEN steps
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_t;

endpackage

`default_nettype wire

//--- src/imuldiv_mul_dpath.sv
// iterative multiplier datapath
// operand registers, add/shift step and final sign correction

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_params.svh"

module imuldiv_mul_dpath
  import imuldiv_data_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  word_t  req_a,
  input  word_t  req_b,

  input  logic   a_en,
  input  logic   a_mux_sel,
  input  logic   b_en,
  input  logic   b_mux_sel,
  input  logic   res_en,
  input  logic   res_mux_sel,

  output dword_t resp_result
);

  // --------------------
  // operand magnitudes
  // --------------------

  logic  sign_a;
  logic  sign_b;
  word_t mag_a;
  word_t mag_b;

  assign sign_a = req_a[`IMULDIV_XLEN-1];
  assign sign_b = req_b[`IMULDIV_XLEN-1];
  // two's complement negate, most negative value maps to 2**31 unsigned
  assign mag_a  = sign_a ? (~req_a + word_t'(1)) : req_a;
  assign mag_b  = sign_b ? (~req_b + word_t'(1)) : req_b;

  // --------------------
  // step registers
  // --------------------

  dword_t a_reg;
  word_t  b_reg;
  dword_t res_reg;
  logic   neg_reg;

  dword_t a_mux_out;
  word_t  b_mux_out;
  dword_t res_mux_out;

  // sel 0 loads the fresh operand, sel 1 takes the shifted value
  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{`IMULDIV_XLEN{1'b0}}, mag_a};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : mag_b;

  // add a only when the current multiplier bit is set
  assign res_mux_out = res_mux_sel ? (b_reg[0] ? res_reg + a_reg : res_reg) : '0;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
  end

  // accumulator and sign flag start clean out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      res_reg <= '0;
      neg_reg <= 1'b0;
    end else begin
      if (res_en) begin
        res_reg <= res_mux_out;
      end
      // sign only captured on the load step
      if (a_en && !a_mux_sel) begin
        neg_reg <= sign_a ^ sign_b;
      end
    end
  end

  // product is negative when exactly one operand was
  assign resp_result = neg_reg ? (~res_reg + dword_t'(1)) : res_reg;

endmodule

`default_nettype wire

//--- src/imuldiv_mul_ctrl.sv
// iterative multiplier control
// state machine, step counter, datapath enables and handshakes

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_params.svh"

module imuldiv_mul_ctrl
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,

  input  logic req_val,
  output logic req_rdy,

  output logic resp_val,
  input  logic resp_rdy,

  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel,
  output logic res_en,
  output logic res_mux_sel
);

  iter_state_t state;
  count_t      count;

  logic req_go;
  logic resp_go;
  logic last_step;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (count == count_t'(`IMULDIV_XLEN - 1));

  // --------------------
  // state and counter
  // --------------------

  // accepting edge loads, then XLEN calc edges before st_done
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_step) begin
            state <= st_done;
          end
          count <= count + count_t'(1);
        end
        st_done: begin
          // result held here until the response is taken
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------

  always_comb begin
    req_rdy  = (state == st_idle);
    resp_val = (state == st_done);

    // load on the accepting edge, shift/accumulate while calculating
    a_en   = (state == st_calc) || req_go;
    b_en   = a_en;
    res_en = a_en;

    a_mux_sel   = (state == st_calc);
    b_mux_sel   = a_mux_sel;
    res_mux_sel = a_mux_sel;
  end

endmodule

`default_nettype wire

//--- src/imuldiv_mul_iterative.sv
// iterative signed multiplier
// joins datapath storage with the control block

`timescale 1ns/1ps
`default_nettype none

module imuldiv_mul_iterative
  import imuldiv_data_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  logic   req_val,
  output logic   req_rdy,
  input  word_t  req_a,
  input  word_t  req_b,

  output logic   resp_val,
  input  logic   resp_rdy,
  output dword_t resp_result
);

  // control to datapath
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;
  logic res_en;
  logic res_mux_sel;

  // holds operands, accumulator and sign
  imuldiv_mul_dpath dpath (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .a_mux_sel   (a_mux_sel),
    .b_en        (b_en),
    .b_mux_sel   (b_mux_sel),
    .res_en      (res_en),
    .res_mux_sel (res_mux_sel),
    .resp_result (resp_result)
  );

  // decides which registers move each cycle
  imuldiv_mul_ctrl ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .a_en        (a_en),
    .a_mux_sel   (a_mux_sel),
    .b_en        (b_en),
    .b_mux_sel   (b_mux_sel),
    .res_en      (res_en),
    .res_mux_sel (res_mux_sel)
  );

endmodule

`default_nettype wire

//--- src/imuldiv_div_iterative.sv
// iterative restoring divider, signed or unsigned
// result is {remainder, quotient}, divide by zero gives all-ones quotient

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_params.svh"

module imuldiv_div_iterative
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  logic   req_val,
  output logic   req_rdy,
  input  logic   req_signed,
  input  word_t  req_a,
  input  word_t  req_b,

  output logic   resp_val,
  input  logic   resp_rdy,
  output dword_t resp_result
);

  localparam int XLEN = `IMULDIV_XLEN;

  iter_state_t state;
  count_t      count;

  logic req_go;
  logic resp_go;
  logic last_step;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (count == count_t'(XLEN - 1));

  // --------------------
  // operand magnitudes
  // --------------------

  logic  neg_a;
  logic  neg_b;
  word_t mag_a;
  word_t mag_b;

  // sign bits only count for signed requests
  assign neg_a = req_signed && req_a[XLEN-1];
  assign neg_b = req_signed && req_b[XLEN-1];
  assign mag_a = neg_a ? (~req_a + word_t'(1)) : req_a;
  assign mag_b = neg_b ? (~req_b + word_t'(1)) : req_b;

  // --------------------
  // restoring step
  // --------------------

  // pair_reg holds {remainder, dividend/quotient}
  dword_t pair_reg;
  word_t  dvsr_reg;
  logic   quo_neg;
  logic   rem_neg;

  logic [XLEN:0]   rem_shift;
  logic [XLEN+1:0] diff;
  dword_t          pair_next;

  // shift one dividend bit into the remainder
  assign rem_shift = pair_reg[2*XLEN-1:XLEN-1];
  assign diff      = {1'b0, rem_shift} - {2'b00, dvsr_reg};

  // keep the difference when it did not go negative, set quotient bit
  always_comb begin
    if (!diff[XLEN+1]) begin
      pair_next = {diff[XLEN-1:0], pair_reg[XLEN-2:0], 1'b1};
    end else begin
      pair_next = {pair_reg[2*XLEN-2:0], 1'b0};
    end
  end

  // payload registers, loaded on accept and stepped in st_calc
  always_ff @(posedge clk) begin
    if (req_go) begin
      pair_reg <= {{XLEN{1'b0}}, mag_a};
      dvsr_reg <= mag_b;
      // zero divisor keeps the all-ones quotient unsigned
      quo_neg  <= (neg_a ^ neg_b) && (req_b != '0);
      // remainder follows the dividend
      rem_neg  <= neg_a;
    end else if (state == st_calc) begin
      pair_reg <= pair_next;
    end
  end

  // --------------------
  // state machine
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_step) begin
            state <= st_done;
          end
          count <= count + count_t'(1);
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // --------------------
  // sign fix on the way out
  // --------------------

  word_t quo_mag;
  word_t rem_mag;

  assign quo_mag = pair_reg[XLEN-1:0];
  assign rem_mag = pair_reg[2*XLEN-1:XLEN];

  assign resp_result = {
    rem_neg ? (~rem_mag + word_t'(1)) : rem_mag,
    quo_neg ? (~quo_mag + word_t'(1)) : quo_mag
  };

endmodule

`default_nettype wire

//--- src/imuldiv_int_muldiv.sv
// multiply/divide top level
// request steering, per-unit tags and round-robin response arbiter

`timescale 1ns/1ps
`default_nettype none

module imuldiv_int_muldiv
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  logic   req_val,
  output logic   req_rdy,
  input  fn_t    req_fn,
  input  word_t  req_a,
  input  word_t  req_b,
  input  tag_t   req_tag,

  output logic   resp_val,
  input  logic   resp_rdy,
  output dword_t resp_result,
  output tag_t   resp_tag
);

  // --------------------
  // request steering
  // --------------------

  logic   is_mul;
  logic   mul_req_val, mul_req_rdy, mul_resp_val, mul_resp_rdy;
  logic   div_req_val, div_req_rdy, div_resp_val, div_resp_rdy;
  dword_t mul_result;
  dword_t div_result;
  tag_t   mul_tag;
  tag_t   div_tag;

  assign is_mul      = (req_fn == fn_mul);
  assign mul_req_val = req_val && is_mul;
  assign div_req_val = req_val && !is_mul;
  assign req_rdy     = is_mul ? mul_req_rdy : div_req_rdy;

  // tag follows the request into whichever unit took it
  always_ff @(posedge clk) begin
    if (mul_req_val && mul_req_rdy) begin
      mul_tag <= req_tag;
    end
    if (div_req_val && div_req_rdy) begin
      div_tag <= req_tag;
    end
  end

  imuldiv_mul_iterative mul_unit (
    .clk (clk), .reset (reset),
    .req_val (mul_req_val), .req_rdy (mul_req_rdy), .req_a (req_a), .req_b (req_b),
    .resp_val (mul_resp_val), .resp_rdy (mul_resp_rdy), .resp_result (mul_result)
  );

  imuldiv_div_iterative div_unit (
    .clk (clk), .reset (reset),
    .req_val (div_req_val), .req_rdy (div_req_rdy), .req_signed (req_fn == fn_div),
    .req_a (req_a), .req_b (req_b),
    .resp_val (div_resp_val), .resp_rdy (div_resp_rdy), .resp_result (div_result)
  );

  // --------------------
  // response arbiter
  // --------------------

  logic last_div;
  logic lock_q;
  logic lock_div_q;
  logic pick_div;

  // a stalled choice stays put so the response is stable until taken
  always_comb begin
    if (lock_q) begin
      pick_div = lock_div_q;
    end else if (mul_resp_val && div_resp_val) begin
      pick_div = !last_div;
    end else begin
      pick_div = div_resp_val;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_div   <= 1'b1;
      lock_q     <= 1'b0;
      lock_div_q <= 1'b0;
    end else if (resp_val && resp_rdy) begin
      last_div <= pick_div;
      lock_q   <= 1'b0;
    end else if (resp_val) begin
      lock_q     <= 1'b1;
      lock_div_q <= pick_div;
    end
  end

  assign resp_val     = mul_resp_val || div_resp_val;
  assign mul_resp_rdy = resp_rdy && !pick_div;
  assign div_resp_rdy = resp_rdy && pick_div;
  assign resp_result  = pick_div ? div_result : mul_result;
  assign resp_tag     = pick_div ? div_tag : mul_tag;

endmodule

`default_nettype wire

//--- verif/imuldiv_assertions.sv
// handshake assertions bound onto the multiply/divide top level

`timescale 1ns/1ps
`default_nettype none

module imuldiv_assertions
  import imuldiv_data_pkg::*;
(
  input logic   clk,
  input logic   reset,
  input logic   req_val,
  input logic   req_rdy,
  input logic   resp_val,
  input logic   resp_rdy,
  input dword_t resp_result,
  input tag_t   resp_tag
);

  // failures so far, read back by the testbench
  int fail_count;
  int open_reqs;

  initial fail_count = 0;

  // requests taken but not yet answered
  always_ff @(posedge clk) begin
    if (reset) begin
      open_reqs <= 0;
    end else begin
      open_reqs <= open_reqs + int'(req_val && req_rdy) - int'(resp_val && resp_rdy);
    end
  end

  // --------------------
  // properties
  // --------------------

  // stalled response keeps valid, result and tag
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result) && $stable(resp_tag))
  else begin
    fail_count++;
    $error("response dropped or changed before it was taken");
  end

  // both units idle one cycle into reset
  assert property (@(posedge clk) reset |=> req_rdy && !resp_val)
  else begin
    fail_count++;
    $error("req_rdy low or resp_val high right after reset");
  end

  // a response needs an earlier accepted request
  assert property (@(posedge clk) disable iff (reset) resp_val |-> open_reqs > 0)
  else begin
    fail_count++;
    $error("resp_val raised with no request outstanding");
  end

endmodule

bind imuldiv_int_muldiv imuldiv_assertions handshake_checks (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result),
  .resp_tag    (resp_tag)
);

`default_nettype wire

//--- verif/imuldiv_checker.sv
// reference model and scoreboard for the multiply/divide unit
// expected results kept by tag, one report line per response

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_params.svh"

module imuldiv_checker
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   req_val,
  input  logic   req_rdy,
  input  fn_t    req_fn,
  input  word_t  req_a,
  input  word_t  req_b,
  input  tag_t   req_tag,
  input  logic   resp_val,
  input  logic   resp_rdy,
  input  dword_t resp_result,
  input  tag_t   resp_tag,
  input  logic   exact_timing,
  output int     test_count,
  output int     error_count,
  output int     outstanding
);

  localparam int TAGS = 1 << `IMULDIV_TAG_W;
  // one load edge, 32 steps, then the taking edge
  localparam int LATENCY = 33;

  dword_t expect_by_tag [TAGS];
  logic   pending       [TAGS];
  int     accept_cycle  [TAGS];
  string  name_by_tag   [TAGS];
  int     cycle;
  int     latency;
  logic   bad_time;

  initial begin
    cycle       = 0;
    test_count  = 0;
    error_count = 0;
    outstanding = 0;
    for (int i = 0; i < TAGS; i++) begin
      pending[i] = 1'b0;
    end
  end

  function void set_name(input tag_t tag, input string name);
    name_by_tag[tag] = name;
  endfunction

  // arithmetic rules: signed product, truncating divide, zero divisor case
  function automatic dword_t model_result(input fn_t fn, input word_t a, input word_t b);
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'(a);
    ub = longint'(b);
    if (fn == fn_mul) begin
      return dword_t'(sa * sb);
    end
    if (b == '0) begin
      return {a, {`IMULDIV_XLEN{1'b1}}};
    end
    if (fn == fn_div) begin
      return {word_t'(sa % sb), word_t'(sa / sb)};
    end
    return {word_t'(ua % ub), word_t'(ua / ub)};
  endfunction

  always @(posedge clk) begin
    if (!reset) begin
      // --------------------
      // response side
      // --------------------
      if (resp_val && resp_rdy) begin
        test_count++;
        if (!pending[resp_tag]) begin
          error_count++;
          $display("response with tag %0d arrived with no request pending", resp_tag);
        end else begin
          pending[resp_tag] = 1'b0;
          outstanding--;
          latency  = cycle - accept_cycle[resp_tag];
          // exact only when nothing stalls or collides
          bad_time = exact_timing ? (latency != LATENCY) : (latency < LATENCY);
          if (resp_result !== expect_by_tag[resp_tag]) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name_by_tag[resp_tag],
                     expect_by_tag[resp_tag], resp_result);
          end else if (bad_time) begin
            error_count++;
            $display("%s was taken %0d edges after its request, expected %0d",
                     name_by_tag[resp_tag], latency, LATENCY);
          end else begin
            $display("ok %s tag %0d result %h", name_by_tag[resp_tag], resp_tag, resp_result);
          end
        end
      end
      // request side
      if (req_val && req_rdy) begin
        expect_by_tag[req_tag] = model_result(req_fn, req_a, req_b);
        pending[req_tag]       = 1'b1;
        accept_cycle[req_tag]  = cycle;
        outstanding++;
      end
    end
    cycle++;
  end

endmodule

`default_nettype wire

//--- verif/imuldiv_tb.sv
// testbench top for the multiply/divide unit
// clock and reset, directed table, random phase with response stalls

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_params.svh"

module imuldiv_tb
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;
();

  localparam int WAIT_LIMIT   = 400;
  localparam int RANDOM_COUNT = 40;

  logic   clk;
  logic   reset;
  logic   req_val;
  logic   req_rdy;
  fn_t    req_fn;
  word_t  req_a;
  word_t  req_b;
  tag_t   req_tag;
  logic   resp_val;
  logic   resp_rdy;
  dword_t resp_result;
  tag_t   resp_tag;

  logic        exact_timing;
  logic        stall_on;
  logic        req_taken;
  logic        timed_out;
  int          test_count;
  int          error_count;
  int          outstanding;
  int          assert_fails;
  int          run_left;
  int unsigned op_state;
  int unsigned stall_state;

  // directed table, one entry per named case
  string name_q [$];
  fn_t   fn_q   [$];
  word_t a_q    [$];
  word_t b_q    [$];

  imuldiv_int_muldiv imuldiv_int_muldiv_inst (
    .clk (clk), .reset (reset),
    .req_val (req_val), .req_rdy (req_rdy), .req_fn (req_fn),
    .req_a (req_a), .req_b (req_b), .req_tag (req_tag),
    .resp_val (resp_val), .resp_rdy (resp_rdy),
    .resp_result (resp_result), .resp_tag (resp_tag)
  );

  imuldiv_checker scoreboard (
    .clk (clk), .reset (reset),
    .req_val (req_val), .req_rdy (req_rdy), .req_fn (req_fn),
    .req_a (req_a), .req_b (req_b), .req_tag (req_tag),
    .resp_val (resp_val), .resp_rdy (resp_rdy),
    .resp_result (resp_result), .resp_tag (resp_tag),
    .exact_timing (exact_timing), .test_count (test_count),
    .error_count (error_count), .outstanding (outstanding)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // acceptance on the last rising edge, read at the falling edge
  always @(posedge clk) begin
    req_taken <= req_val && req_rdy;
  end

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic add_entry(input string name, input fn_t fn, input word_t a, input word_t b);
    name_q.push_back(name);
    fn_q.push_back(fn);
    a_q.push_back(a);
    b_q.push_back(b);
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    timed_out = 1'b1;
  endtask

  // drive on the falling edge, hold until the steered unit takes it
  task automatic send_request(input string name, input fn_t fn, input word_t a, input word_t b);
    int waited;
    waited = 0;
    if (!timed_out) begin
      scoreboard.set_name(req_tag, name);
      req_fn  = fn;
      req_a   = a;
      req_b   = b;
      req_val = 1'b1;
      do begin
        @(negedge clk);
        waited++;
      end while (!req_taken && waited < WAIT_LIMIT);
      req_val = 1'b0;
      if (!req_taken) begin
        report_timeout({"acceptance of ", name});
      end else begin
        req_tag = req_tag + tag_t'(1);
      end
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    if (!timed_out) begin
      while (outstanding != 0 && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (outstanding != 0) begin
        report_timeout("outstanding responses");
      end
    end
  endtask

  // --------------------
  // response stalls
  // --------------------

  // random stretches of resp_rdy high or low, 1 to 8 cycles each
  initial begin
    resp_rdy    = 1'b1;
    run_left    = 0;
    stall_state = lcg_step(32'd19775);
    forever begin
      @(negedge clk);
      if (!stall_on) begin
        resp_rdy = 1'b1;
      end else begin
        if (run_left == 0) begin
          stall_state = lcg_step(stall_state);
          resp_rdy    = stall_state[16];
          run_left    = int'(stall_state[19:17]) + 1;
        end
        run_left--;
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------

  initial begin
    int unsigned pick;
    word_t       a;
    word_t       b;
    fn_t         fn;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_fn       = fn_mul;
    req_a        = '0;
    req_b        = '0;
    req_tag      = '0;
    exact_timing = 1'b1;
    stall_on     = 1'b0;
    timed_out    = 1'b0;
    op_state     = 32'd19775;

    add_entry("mul_pos",       fn_mul,  32'd7,          32'd6);
    add_entry("mul_neg_pos",   fn_mul,  32'hfffffffd,   32'd9);
    add_entry("mul_neg_neg",   fn_mul,  -32'sd12345,    -32'sd678);
    add_entry("mul_zero",      fn_mul,  32'd0,          32'hdeadbeef);
    add_entry("mul_min_min",   fn_mul,  32'h80000000,   32'h80000000);
    add_entry("mul_min_neg1",  fn_mul,  32'h80000000,   32'hffffffff);
    add_entry("div_pos",       fn_div,  32'd100,        32'd7);
    add_entry("div_neg_num",   fn_div,  -32'sd100,      32'd7);
    add_entry("div_neg_den",   fn_div,  32'd100,        -32'sd7);
    add_entry("divu_big",      fn_divu, 32'hfffffff0,   32'd3);
    add_entry("div_by_zero",   fn_div,  -32'sd5,        32'd0);
    add_entry("divu_by_zero",  fn_divu, 32'h12345678,   32'd0);
    add_entry("div_min_neg1",  fn_div,  32'h80000000,   32'hffffffff);

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // one request at a time, each with its own tag
    for (int i = 0; i < name_q.size(); i++) begin
      send_request(name_q[i], fn_q[i], a_q[i], b_q[i]);
      wait_for_drain();
    end

    // multiply and divide in flight together
    send_request("pair_mul", fn_mul, 32'h0001ffff, 32'hffff0003);
    send_request("pair_div", fn_divu, 32'hcafef00d, 32'd1000);
    wait_for_drain();

    // random operands and functions under resp_rdy stalls
    exact_timing = 1'b0;
    stall_on     = 1'b1;
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      op_state = lcg_step(op_state);
      pick     = (op_state >> 16) % 3;
      op_state = lcg_step(op_state);
      a        = op_state;
      op_state = lcg_step(op_state);
      b        = op_state;
      // zero and small divisors now and then
      if (op_state[27:25] == 3'd0) begin
        b = '0;
      end else if (op_state[24]) begin
        b = word_t'(op_state[23:16]);
      end
      case (pick)
        0:       fn = fn_mul;
        1:       fn = fn_div;
        default: fn = fn_divu;
      endcase
      send_request($sformatf("rand_%0d", i), fn, a, b);
    end
    stall_on = 1'b0;
    wait_for_drain();

    assert_fails = imuldiv_int_muldiv_inst.handshake_checks.fail_count;
    $display("%0d responses checked, %0d errors, %0d assertion failures",
             test_count, error_count, assert_fails);
    if (!timed_out && error_count == 0 && assert_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/imuldiv_data_pkg.sv
src/imuldiv_ctrl_pkg.sv
src/imuldiv_mul_dpath.sv
src/imuldiv_mul_ctrl.sv
src/imuldiv_mul_iterative.sv
src/imuldiv_div_iterative.sv
src/imuldiv_int_muldiv.sv
verif/imuldiv_assertions.sv
verif/imuldiv_checker.sv
verif/imuldiv_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = imuldiv_tb
FILELIST = compile.f
SIM_ARGS = +verilator+error+limit+1000
BUILD    = obj_dir
LOG      = sim.log
PASS     = test passed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
